// ==== hw/qdc_pkg.sv ====
// Shared types and constants for the constant-decode block and its register port
// Other files reach these by scoped names such as qdc_pkg::OP_ADDI

package qdc_pkg;

// ============================================================
// Sizes
// ============================================================

// One instruction plus three constant parcels
localparam int INSTR_BITS = 192;
// Three 40-bit parcel payloads once the header bytes are dropped
localparam int CZONE_BITS = 120;
// Wishbone word address and data widths
localparam int WB_AW = 6;
localparam int WB_DW = 32;

// ============================================================
// Register map, word addresses
// ============================================================

// Instruction block, low word first
localparam logic [WB_AW-1:0] REG_BLK0 = 6'd0;
localparam logic [WB_AW-1:0] REG_BLK1 = 6'd1;
localparam logic [WB_AW-1:0] REG_BLK2 = 6'd2;
localparam logic [WB_AW-1:0] REG_BLK3 = 6'd3;
localparam logic [WB_AW-1:0] REG_BLK4 = 6'd4;
localparam logic [WB_AW-1:0] REG_BLK5 = 6'd5;
// Any write here captures the decoder output
localparam logic [WB_AW-1:0] REG_CTRL = 6'd8;
// Immediates a through d, low half then high half
localparam logic [WB_AW-1:0] REG_IMM0 = 6'd16;
localparam logic [WB_AW-1:0] REG_IMM1 = 6'd17;
localparam logic [WB_AW-1:0] REG_IMM2 = 6'd18;
localparam logic [WB_AW-1:0] REG_IMM3 = 6'd19;
localparam logic [WB_AW-1:0] REG_IMM4 = 6'd20;
localparam logic [WB_AW-1:0] REG_IMM5 = 6'd21;
localparam logic [WB_AW-1:0] REG_IMM6 = 6'd22;
localparam logic [WB_AW-1:0] REG_IMM7 = 6'd23;
// has_imm in [3:0], isz in [9:4], pos in [21:10]
localparam logic [WB_AW-1:0] REG_FLAGS = 6'd24;

// ============================================================
// Encodings
// ============================================================

typedef enum logic [6:0] {
	OP_ADDI  = 7'd4,
	OP_ANDI  = 7'd8,
	OP_CMPI  = 7'd11,
	OP_FLTD  = 7'd20,
	OP_BR    = 7'd32,
	OP_BCC   = 7'd40,
	OP_LOAD  = 7'd64,
	OP_STORE = 7'd80,
	OP_STI   = 7'd82,
	OP_FENCE = 7'd120
} opcode_e;

// Size of a constant taken from the zone
typedef enum logic [1:0] {
	CSZ_NONE = 2'd0,
	CSZ_16   = 2'd1,
	CSZ_32   = 2'd2,
	CSZ_64   = 2'd3
} csize_e;

// Slot index 0 is operand a, 1 is b, 2 is c
typedef logic [2:0][3:0] const_pos_t;
typedef logic [2:0][1:0] const_size_t;

// ============================================================
// Instruction formats
// ============================================================

typedef struct packed {
	logic [40:0] body;
	opcode_e     opcode;
} fmt_any_t;

// Register-immediate ops, bit 0 of cflag belongs to rs1
typedef struct packed {
	const_pos_t  cpos;
	const_size_t csz;
	logic [2:0]  cflag;
	logic [4:0]  rs3;
	logic [4:0]  rs2;
	logic [4:0]  rs1;
	logic [4:0]  rd;
	opcode_e     opcode;
} fmt_alu_t;

typedef struct packed {
	logic [26:0] disp;
	logic        exconst;
	logic [2:0]  cond;
	logic [4:0]  rs2;
	logic [4:0]  rs1;
	opcode_e     opcode;
} fmt_br_t;

// Loads and stores, slot d carries store-immediate data
typedef struct packed {
	logic [12:0] disp;
	logic [3:0]  cpos_d;
	logic [1:0]  csz_d;
	logic [3:0]  cpos_c;
	logic [1:0]  csz_c;
	logic        cflag_c;
	logic [4:0]  rs2;
	logic [4:0]  rs1;
	logic [4:0]  rd;
	opcode_e     opcode;
} fmt_mem_t;

// The same 48-bit word read through whichever view the opcode picks
typedef union packed {
	fmt_any_t any;
	fmt_alu_t alu;
	fmt_br_t  br;
	fmt_mem_t mem;
} micro_op_t;

// Everything the decoder hands back for one instruction
typedef struct packed {
	logic [63:0] imma;
	logic [63:0] immb;
	logic [63:0] immc;
	logic [63:0] immd;
	logic [3:0]  has_imm;
	const_pos_t  pos;
	const_size_t isz;
} dec_result_t;

endpackage

// ==== hw/constant_decoder.sv ====
// Extracts one constant from the 120-bit constant zone
// Byte position and size code come from the instruction; output is always 64 bits

`timescale 1ns/1ps

module constant_decoder
(
	input  logic [3:0]                    pos,
	input  qdc_pkg::csize_e               size,
	input  logic [qdc_pkg::CZONE_BITS-1:0] czone,
	output logic [63:0]                   cnst
);

	// Zone moved down so the wanted constant starts at bit 0
	logic [qdc_pkg::CZONE_BITS-1:0] shifted;

	// A logical shift brings in zeros from above, which gives the
	// zero fill when a 64-bit constant runs past the end of the zone
	always_comb
		shifted = czone >> {pos, 3'b000};

	always_comb
	begin
		case (size)
		qdc_pkg::CSZ_16:
			// Halfword, sign-extended
			cnst = {{48{shifted[15]}}, shifted[15:0]};
		qdc_pkg::CSZ_32:
			// Word, sign-extended
			cnst = {{32{shifted[31]}}, shifted[31:0]};
		qdc_pkg::CSZ_64:
			cnst = shifted[63:0];
		default:
			// No constant in this slot
			cnst = 64'd0;
		endcase
	end

endmodule

// ==== hw/fp_widen.sv ====
// Widens a half- or single-precision value to double precision
// Pure combinational; the half sits in the low 16 bits of src

`timescale 1ns/1ps

module fp_widen
(
	input  logic [31:0] src,
	input  logic        is_half,
	output logic [63:0] dst
);

	// Fields unpacked into a common single-precision shape
	logic        sgn;
	logic [7:0]  exp_in;
	logic [22:0] man_in;
	logic        exp_max;
	// Added to the source exponent to re-bias it for double
	logic [10:0] bias_adj;
	// Leading zeros of the fraction, used only for subnormals
	logic [4:0]  lz;
	logic [22:0] man_norm;

	// Count of zeros above the first set bit, 23 when all clear
	function automatic logic [4:0] lzc23(input logic [22:0] v);
		logic [4:0] n;
		logic       hit;
		n = 5'd23;
		hit = 1'b0;
		for (int i = 22; i >= 0; i--)
		begin
			if (!hit && v[i])
			begin
				n = 5'(22 - i);
				hit = 1'b1;
			end
		end
		return n;
	endfunction

	always_comb
	begin
		if (is_half)
		begin
			sgn = src[15];
			exp_in = {3'b000, src[14:10]};
			// Half fraction is left-aligned so payloads line up
			man_in = {src[9:0], 13'd0};
			exp_max = &src[14:10];
			bias_adj = 11'd1008;
		end
		else
		begin
			sgn = src[31];
			exp_in = src[30:23];
			man_in = src[22:0];
			exp_max = &src[30:23];
			bias_adj = 11'd896;
		end
	end

	// Shift past the leading one, which becomes the hidden bit
	always_comb
	begin
		lz = lzc23(man_in);
		man_norm = man_in << (lz + 5'd1);
	end

	always_comb
	begin
		if (exp_in == 8'd0 && man_in == 23'd0)
			// Signed zero
			dst = {sgn, 63'd0};
		else if (exp_max)
			// Infinity or NaN keeps its fraction at the top
			dst = {sgn, 11'h7ff, man_in, 29'd0};
		else if (exp_in == 8'd0)
			// Subnormal source is a normal double
			dst = {sgn, bias_adj - {6'd0, lz}, man_norm, 29'd0};
		else
			dst = {sgn, bias_adj + {3'd0, exp_in}, man_in, 29'd0};
	end

endmodule

// ==== hw/decode_const.sv ====
// Decodes the instruction at the bottom of a 192-bit block into four immediates
// The three parcels above it supply the constant zone; headers are ignored

`timescale 1ns/1ps

module decode_const
(
	input  logic [qdc_pkg::INSTR_BITS-1:0] instr_raw,
	output qdc_pkg::dec_result_t           res
);

	qdc_pkg::micro_op_t ins;
	logic [qdc_pkg::CZONE_BITS-1:0] czone;
	qdc_pkg::const_pos_t  pos;
	qdc_pkg::const_size_t isz;

	// Raw slot constants, then the float-widened forms of slots a to c
	logic [63:0] cnst_a;
	logic [63:0] cnst_b;
	logic [63:0] cnst_c;
	logic [63:0] cnst_d;
	logic [63:0] flt_a;
	logic [63:0] flt_b;
	logic [63:0] flt_c;

	// Branch and memory displacements as 64-bit values
	logic [63:0] br_disp;
	logic [63:0] mem_disp;

	always_comb
		ins = qdc_pkg::micro_op_t'(instr_raw[47:0]);

	// Each parcel has its header in the low byte, payload above it
	always_comb
		czone = {instr_raw[191:152], instr_raw[143:104], instr_raw[95:56]};

	// ============================================================
	// Slot positions and sizes, per format
	// ============================================================

	always_comb
	begin
		pos = '0;
		isz = '0;
		case (ins.any.opcode)
		qdc_pkg::OP_ADDI, qdc_pkg::OP_ANDI, qdc_pkg::OP_CMPI, qdc_pkg::OP_FLTD:
		begin
			pos = ins.alu.cpos;
			isz = ins.alu.csz;
		end
		qdc_pkg::OP_BR, qdc_pkg::OP_BCC:
			// An extended branch target is a full 64-bit word at byte 0
			if (ins.br.exconst)
				isz[0] = qdc_pkg::CSZ_64;
		qdc_pkg::OP_LOAD, qdc_pkg::OP_STORE, qdc_pkg::OP_STI:
		begin
			pos[2] = ins.mem.cpos_c;
			isz[2] = ins.mem.csz_c;
		end
		default:
		begin
			pos = '0;
			isz = '0;
		end
		endcase
	end

	constant_decoder u_cdec_a (
		.pos(pos[0]), .size(qdc_pkg::csize_e'(isz[0])), .czone(czone), .cnst(cnst_a)
	);
	constant_decoder u_cdec_b (
		.pos(pos[1]), .size(qdc_pkg::csize_e'(isz[1])), .czone(czone), .cnst(cnst_b)
	);
	constant_decoder u_cdec_c (
		.pos(pos[2]), .size(qdc_pkg::csize_e'(isz[2])), .czone(czone), .cnst(cnst_c)
	);
	// Store-immediate data has its own slot outside pos and isz
	constant_decoder u_cdec_d (
		.pos(ins.mem.cpos_d), .size(qdc_pkg::csize_e'(ins.mem.csz_d)),
		.czone(czone), .cnst(cnst_d)
	);

	// Only the low 16 or 32 bits of each slot matter for widening
	fp_widen u_fpw_a (
		.src(cnst_a[31:0]), .is_half(isz[0] == qdc_pkg::CSZ_16), .dst(flt_a)
	);
	fp_widen u_fpw_b (
		.src(cnst_b[31:0]), .is_half(isz[1] == qdc_pkg::CSZ_16), .dst(flt_b)
	);
	fp_widen u_fpw_c (
		.src(cnst_c[31:0]), .is_half(isz[2] == qdc_pkg::CSZ_16), .dst(flt_c)
	);

	// Branch offsets count words, so scale by four
	always_comb
		br_disp = {{35{ins.br.disp[26]}}, ins.br.disp, 2'b00};

	always_comb
		mem_disp = {{51{ins.mem.disp[12]}}, ins.mem.disp};

	// ============================================================
	// Immediate selection by opcode
	// ============================================================

	always_comb
	begin
		res = '0;
		res.pos = pos;
		res.isz = isz;
		case (ins.any.opcode)
		qdc_pkg::OP_ADDI, qdc_pkg::OP_ANDI, qdc_pkg::OP_CMPI:
		begin
			res.imma = cnst_a;
			res.immb = cnst_b;
			res.immc = cnst_c;
			res.has_imm[2:0] = ins.alu.cflag;
		end
		qdc_pkg::OP_FLTD:
		begin
			// Narrow slots hold float values, 64-bit slots are already double
			res.imma = (isz[0] == qdc_pkg::CSZ_16 || isz[0] == qdc_pkg::CSZ_32) ? flt_a : cnst_a;
			res.immb = (isz[1] == qdc_pkg::CSZ_16 || isz[1] == qdc_pkg::CSZ_32) ? flt_b : cnst_b;
			res.immc = (isz[2] == qdc_pkg::CSZ_16 || isz[2] == qdc_pkg::CSZ_32) ? flt_c : cnst_c;
			res.has_imm[2:0] = ins.alu.cflag;
		end
		qdc_pkg::OP_BR:
		begin
			res.immb = ins.br.exconst ? cnst_a : br_disp;
			res.has_imm[1] = 1'b1;
		end
		qdc_pkg::OP_BCC:
		begin
			res.immb = ins.br.exconst ? cnst_a : br_disp;
			// Condition 4 has no target in this format
			res.has_imm[1] = (ins.br.cond != 3'd4);
		end
		qdc_pkg::OP_LOAD, qdc_pkg::OP_STORE:
		begin
			res.immc = ins.mem.cflag_c ? cnst_c : mem_disp;
			res.has_imm[2] = ins.mem.cflag_c;
		end
		qdc_pkg::OP_STI:
		begin
			res.immc = ins.mem.cflag_c ? cnst_c : mem_disp;
			res.has_imm[2] = ins.mem.cflag_c;
			res.immd = cnst_d;
			res.has_imm[3] = 1'b1;
		end
		qdc_pkg::OP_FENCE:
		begin
			// Fence mode field, unsigned
			res.immb = {48'd0, instr_raw[22:7]};
			res.has_imm[1] = 1'b1;
		end
		default:
			res.has_imm = 4'd0;
		endcase
	end

endmodule

// ==== hw/wb_decode_regs.sv ====
// Wishbone classic slave in front of the constant decoder
// Holds the instruction block, latches decode results on a REG_CTRL write

`timescale 1ns/1ps

module wb_decode_regs
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            cyc,
	input  logic                            stb,
	input  logic                            we,
	input  logic [qdc_pkg::WB_AW-1:0]       adr,
	input  logic [qdc_pkg::WB_DW-1:0]       dat_w,
	input  logic [3:0]                      sel,
	output logic [qdc_pkg::WB_DW-1:0]       dat_r,
	output logic                            ack,
	output logic [qdc_pkg::INSTR_BITS-1:0]  instr_raw,
	input  qdc_pkg::dec_result_t            res
);

	// Six block words, word 0 holds the low bits of the instruction
	logic [5:0][qdc_pkg::WB_DW-1:0] blk;
	qdc_pkg::dec_result_t res_q;

	// A request is taken on the edge where ack is still low
	logic acc;
	logic [5:0] blk_hit;
	logic ctrl_hit;
	logic [qdc_pkg::WB_DW-1:0] rd_data;

	always_comb
		acc = cyc & stb & ~ack;

	always_comb
		instr_raw = blk;

	// ============================================================
	// Address decode
	// ============================================================

	always_comb
	begin
		blk_hit = 6'd0;
		ctrl_hit = 1'b0;
		case (adr)
		qdc_pkg::REG_BLK0: blk_hit[0] = 1'b1;
		qdc_pkg::REG_BLK1: blk_hit[1] = 1'b1;
		qdc_pkg::REG_BLK2: blk_hit[2] = 1'b1;
		qdc_pkg::REG_BLK3: blk_hit[3] = 1'b1;
		qdc_pkg::REG_BLK4: blk_hit[4] = 1'b1;
		qdc_pkg::REG_BLK5: blk_hit[5] = 1'b1;
		qdc_pkg::REG_CTRL: ctrl_hit = 1'b1;
		default: ctrl_hit = 1'b0;
		endcase
	end

	// Read mux, unmapped words and the control word read as zero
	always_comb
	begin
		case (adr)
		qdc_pkg::REG_BLK0:  rd_data = blk[0];
		qdc_pkg::REG_BLK1:  rd_data = blk[1];
		qdc_pkg::REG_BLK2:  rd_data = blk[2];
		qdc_pkg::REG_BLK3:  rd_data = blk[3];
		qdc_pkg::REG_BLK4:  rd_data = blk[4];
		qdc_pkg::REG_BLK5:  rd_data = blk[5];
		qdc_pkg::REG_IMM0:  rd_data = res_q.imma[31:0];
		qdc_pkg::REG_IMM1:  rd_data = res_q.imma[63:32];
		qdc_pkg::REG_IMM2:  rd_data = res_q.immb[31:0];
		qdc_pkg::REG_IMM3:  rd_data = res_q.immb[63:32];
		qdc_pkg::REG_IMM4:  rd_data = res_q.immc[31:0];
		qdc_pkg::REG_IMM5:  rd_data = res_q.immc[63:32];
		qdc_pkg::REG_IMM6:  rd_data = res_q.immd[31:0];
		qdc_pkg::REG_IMM7:  rd_data = res_q.immd[63:32];
		qdc_pkg::REG_FLAGS: rd_data = {10'd0, res_q.pos, res_q.isz, res_q.has_imm};
		default:            rd_data = 32'd0;
		endcase
	end

	// ============================================================
	// Registers
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ack <= 1'b0;
			blk <= '0;
			res_q <= '0;
		end
		else
		begin
			// One-cycle ack that always drops before the next one
			ack <= acc;
			if (acc && we)
			begin
				for (int w = 0; w < 6; w++)
				begin
					if (blk_hit[w])
					begin
						for (int b = 0; b < 4; b++)
						begin
							if (sel[b])
								blk[w][8*b +: 8] <= dat_w[8*b +: 8];
						end
					end
				end
				// Decoder output follows blk combinationally, so it is settled here
				if (ctrl_hit)
					res_q <= res;
			end
		end
	end

	// Read data lines up with ack
	always_ff @(posedge clk)
	begin
		if (acc)
			dat_r <= rd_data;
	end

endmodule

// ==== hw/decode_const_top.sv ====
// Top level of the constant-decode block as seen from a Wishbone host
// The register port feeds the block to the decoder and captures its output

`timescale 1ns/1ps

module decode_const_top
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      cyc,
	input  logic                      stb,
	input  logic                      we,
	input  logic [qdc_pkg::WB_AW-1:0] adr,
	input  logic [qdc_pkg::WB_DW-1:0] dat_w,
	input  logic [3:0]                sel,
	output logic [qdc_pkg::WB_DW-1:0] dat_r,
	output logic                      ack
);

	logic [qdc_pkg::INSTR_BITS-1:0] instr_raw;
	qdc_pkg::dec_result_t dec_res;

	wb_decode_regs u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.dat_w    (dat_w),
		.sel      (sel),
		.dat_r    (dat_r),
		.ack      (ack),
		.instr_raw(instr_raw),
		.res      (dec_res)
	);

	// Purely combinational, result is ready in the same cycle
	decode_const u_dec (
		.instr_raw(instr_raw),
		.res      (dec_res)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
// Clock and reset source for the constant-decode testbench
// 40 ns clock, rst_n held low for the first five rising edges

`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
	end

	// Half period of 20 ns
	always #20 clk = ~clk;

	// Release lands 2 ns after an edge, in step with the other stimulus
	initial
	begin
		repeat (5) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// ==== verification/tb_decode_const.sv ====
// Table-driven testbench for the constant-decode block behind its Wishbone port
// Each vector is written as a 192-bit block, decoded, read back and compared

`timescale 1ns/1ps

module tb_decode_const;

	localparam int NUM_VECTORS = 14;
	// Each vector costs about 32 cycles of bus traffic
	localparam int TIMEOUT_CYCLES = NUM_VECTORS * 40 + 200;

	// One row of stimulus and its expected decode
	typedef struct packed {
		logic [47:0] instr;
		logic [39:0] pay0;
		logic [39:0] pay1;
		logic [39:0] pay2;
		logic [63:0] imma;
		logic [63:0] immb;
		logic [63:0] immc;
		logic [63:0] immd;
		logic [3:0]  has_imm;
		logic [11:0] pos;
		logic [5:0]  isz;
	} vec_t;

	logic clk;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [qdc_pkg::WB_AW-1:0] adr;
	logic [qdc_pkg::WB_DW-1:0] dat_w;
	logic [3:0] sel;
	logic [qdc_pkg::WB_DW-1:0] dat_r;
	logic ack;

	vec_t vectors [NUM_VECTORS];
	int cycle_count = 0;

	tb_clock_gen u_clk (
		.clk  (clk),
		.rst_n(rst_n)
	);

	decode_const_top dut (
		.clk  (clk),
		.rst_n(rst_n),
		.cyc  (cyc),
		.stb  (stb),
		.we   (we),
		.adr  (adr),
		.dat_w(dat_w),
		.sel  (sel),
		.dat_r(dat_r),
		.ack  (ack)
	);

	// ============================================================
	// Checking and bus access
	// ============================================================

	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act)
		begin
			$display("[ERROR] %0t ns: %s expected %h got %h", $time, what, exp, act);
			$display(">>> FAIL");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// Called 2 ns after an edge; the first look at ack is after the next edge,
	// so a leftover ack from the previous cycle is never mistaken for this one
	task automatic wait_for_ack();
		do
		begin
			@(posedge clk);
			#2;
		end
		while (ack !== 1'b1);
	endtask

	task automatic write_reg(input logic [qdc_pkg::WB_AW-1:0] a, input logic [31:0] d,
		input logic [3:0] s);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		dat_w = d;
		sel = s;
		wait_for_ack();
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	// Read data is registered together with ack
	task automatic read_reg(input logic [qdc_pkg::WB_AW-1:0] a, output logic [31:0] d);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		sel = 4'hF;
		wait_for_ack();
		d = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	// Low word sits at the even address and the high word right after it
	task automatic read_imm64(input logic [qdc_pkg::WB_AW-1:0] a, output logic [63:0] v);
		logic [31:0] lo;
		logic [31:0] hi;
		read_reg(a, lo);
		read_reg(a + 6'd1, hi);
		v = {hi, lo};
	endtask

	// ============================================================
	// Instruction encoders, field layout of the four formats
	// ============================================================

	// Register fields hold a fixed pattern that the decode must ignore
	function automatic logic [47:0] alu_word(input logic [6:0] op, input logic [2:0] cflag,
		input logic [1:0] sz_a, input logic [1:0] sz_b, input logic [1:0] sz_c,
		input logic [3:0] pos_a, input logic [3:0] pos_b, input logic [3:0] pos_c);
		return {pos_c, pos_b, pos_a, sz_c, sz_b, sz_a, cflag, 20'hA5A5A, op};
	endfunction

	function automatic logic [47:0] br_word(input logic [6:0] op, input logic [2:0] cond,
		input logic exconst, input logic [26:0] disp);
		return {disp, exconst, cond, 10'h2A5, op};
	endfunction

	function automatic logic [47:0] mem_word(input logic [6:0] op, input logic cflag_c,
		input logic [1:0] sz_c, input logic [3:0] pos_c, input logic [1:0] sz_d,
		input logic [3:0] pos_d, input logic [12:0] disp);
		return {disp, pos_d, sz_d, pos_c, sz_c, cflag_c, 15'h5A5A, op};
	endfunction

	function automatic logic [47:0] fence_word(input logic [15:0] field);
		return {25'h0F0F0F0, field, qdc_pkg::OP_FENCE};
	endfunction

	task automatic set_vector(input int idx, input logic [47:0] instr,
		input logic [39:0] p0, input logic [39:0] p1, input logic [39:0] p2,
		input logic [63:0] a, input logic [63:0] b, input logic [63:0] c,
		input logic [63:0] d, input logic [3:0] has, input logic [11:0] pos,
		input logic [5:0] isz);
		vectors[idx] = '{instr, p0, p1, p2, a, b, c, d, has, pos, isz};
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================

	// Zone byte k is byte k mod 5 of payload k/5, so pay0 holds bytes 4 down to 0.
	// Expected pos is {c, b, a} nibbles and isz is {c, b, a} size codes
	task automatic fill_vectors();
		// ADDI with a 16-bit at byte 0, a 32-bit at byte 2 and a 64-bit at byte 6
		set_vector(0, alu_word(qdc_pkg::OP_ADDI, 3'b111, 2'd1, 2'd2, 2'd3, 4'd0, 4'd2, 4'd6),
			40'h34_5678_8001, 40'h89_ABCD_EFF2, 40'h5A_0123_4567,
			64'hFFFF_FFFF_FFFF_8001, 64'hFFFF_FFFF_F234_5678, 64'h0123_4567_89AB_CDEF,
			64'd0, 4'b0111, 12'h620, 6'h39);
		// ANDI with no flags and no sizes still reports its positions
		set_vector(1, alu_word(qdc_pkg::OP_ANDI, 3'b000, 2'd0, 2'd0, 2'd0, 4'd7, 4'd5, 4'd3),
			40'h34_5678_8001, 40'h89_ABCD_EFF2, 40'h5A_0123_4567,
			64'd0, 64'd0, 64'd0, 64'd0, 4'b0000, 12'h357, 6'h00);
		// Half 1.5, single -2.0 and half subnormal 3 * 2^-24
		set_vector(2, alu_word(qdc_pkg::OP_FLTD, 3'b111, 2'd1, 2'd2, 2'd1, 4'd0, 4'd2, 4'd6),
			40'h00_0000_3E00, 40'h00_0000_03C0, 40'h00_0000_0000,
			64'h3FF8_0000_0000_0000, 64'hC000_0000_0000_0000, 64'h3E88_0000_0000_0000,
			64'd0, 4'b0111, 12'h620, 6'h19);
		// Half infinity and a 64-bit double that passes through untouched
		set_vector(3, alu_word(qdc_pkg::OP_FLTD, 3'b011, 2'd1, 2'd3, 2'd0, 4'd3, 4'd7, 4'd0),
			40'h7C_0000_0000, 40'h44_2D18_0000, 40'h40_0921_FB54,
			64'h7FF0_0000_0000_0000, 64'h4009_21FB_5444_2D18, 64'd0,
			64'd0, 4'b0011, 12'h073, 6'h0D);
		// Branch displacements count words
		set_vector(4, br_word(qdc_pkg::OP_BR, 3'd0, 1'b0, 27'h000_0100),
			40'h34_5678_8001, 40'h89_ABCD_EFF2, 40'h5A_0123_4567,
			64'd0, 64'h0000_0000_0000_0400, 64'd0, 64'd0, 4'b0010, 12'h000, 6'h00);
		set_vector(5, br_word(qdc_pkg::OP_BR, 3'd1, 1'b0, 27'h7FF_FFFD),
			40'h34_5678_8001, 40'h89_ABCD_EFF2, 40'h5A_0123_4567,
			64'd0, 64'hFFFF_FFFF_FFFF_FFF4, 64'd0, 64'd0, 4'b0010, 12'h000, 6'h00);
		// Extended target is the 64-bit word at zone byte 0
		set_vector(6, br_word(qdc_pkg::OP_BR, 3'd0, 1'b1, 27'd5),
			40'hEF_0BAD_F00D, 40'h77_66DE_ADBE, 40'h11_2233_4455,
			64'd0, 64'hDEAD_BEEF_0BAD_F00D, 64'd0, 64'd0, 4'b0010, 12'h000, 6'h03);
		// Condition 4 carries no target, though immb is still formed
		set_vector(7, br_word(qdc_pkg::OP_BCC, 3'd4, 1'b0, 27'h000_0010),
			40'h34_5678_8001, 40'h89_ABCD_EFF2, 40'h5A_0123_4567,
			64'd0, 64'h0000_0000_0000_0040, 64'd0, 64'd0, 4'b0000, 12'h000, 6'h00);
		set_vector(8, br_word(qdc_pkg::OP_BCC, 3'd2, 1'b0, 27'h7FF_FFFF),
			40'h34_5678_8001, 40'h89_ABCD_EFF2, 40'h5A_0123_4567,
			64'd0, 64'hFFFF_FFFF_FFFF_FFFC, 64'd0, 64'd0, 4'b0010, 12'h000, 6'h00);
		// LOAD with a negative 13-bit displacement
		set_vector(9, mem_word(qdc_pkg::OP_LOAD, 1'b0, 2'd0, 4'd0, 2'd0, 4'd0, 13'h1FF0),
			40'h34_5678_8001, 40'h89_ABCD_EFF2, 40'h5A_0123_4567,
			64'd0, 64'd0, 64'hFFFF_FFFF_FFFF_FFF0, 64'd0, 4'b0000, 12'h000, 6'h00);
		// LOAD with a 32-bit constant c at byte 5
		set_vector(10, mem_word(qdc_pkg::OP_LOAD, 1'b1, 2'd2, 4'd5, 2'd0, 4'd0, 13'd7),
			40'h00_0000_0000, 40'h00_8765_4321, 40'h00_0000_0000,
			64'd0, 64'd0, 64'hFFFF_FFFF_8765_4321, 64'd0, 4'b0100, 12'h500, 6'h20);
		// STI store data runs off the end of the zone and is zero-filled
		set_vector(11, mem_word(qdc_pkg::OP_STI, 1'b1, 2'd1, 4'd0, 2'd3, 4'd8, 13'h0040),
			40'h00_0000_7FFE, 40'h66_7700_0000, 40'h11_2233_4455,
			64'd0, 64'd0, 64'h0000_0000_0000_7FFE, 64'h0011_2233_4455_6677,
			4'b1100, 12'h000, 6'h10);
		set_vector(12, fence_word(16'hA5C3),
			40'h34_5678_8001, 40'h89_ABCD_EFF2, 40'h5A_0123_4567,
			64'd0, 64'h0000_0000_0000_A5C3, 64'd0, 64'd0, 4'b0010, 12'h000, 6'h00);
		// Opcode 127 is not defined, so everything reads as zero
		set_vector(13, 48'hFFFF_FFFF_FFFF,
			40'hFF_FFFF_FFFF, 40'hFF_FFFF_FFFF, 40'hFF_FFFF_FFFF,
			64'd0, 64'd0, 64'd0, 64'd0, 4'b0000, 12'h000, 6'h00);
	endtask

	// ============================================================
	// Test sequences
	// ============================================================

	// Result registers hold zero until the first decode is captured
	task automatic after_reset_zero();
		logic [63:0] v;
		logic [31:0] w;
		for (int k = 0; k < 4; k++)
		begin
			read_imm64(qdc_pkg::REG_IMM0 + 6'(2 * k), v);
			check($sformatf("reset immediate %0d", k), 64'd0, v);
		end
		read_reg(qdc_pkg::REG_FLAGS, w);
		check("reset flags", 64'd0, {32'd0, w});
	endtask

	// Masked lanes keep their old bytes; unmapped words ignore writes
	task automatic byte_lane_writes();
		logic [31:0] w;
		write_reg(qdc_pkg::REG_BLK0, 32'hFFFF_FFFF, 4'hF);
		write_reg(qdc_pkg::REG_BLK0, 32'h0000_0000, 4'b0101);
		read_reg(qdc_pkg::REG_BLK0, w);
		check("byte lane write", 64'h0000_0000_FF00_FF00, {32'd0, w});
		write_reg(6'd40, 32'hDEAD_BEEF, 4'hF);
		read_reg(6'd40, w);
		check("unmapped read", 64'd0, {32'd0, w});
	endtask

	task automatic run_vector(input int idx);
		vec_t v;
		logic [7:0] hdr0;
		logic [7:0] hdr1;
		logic [7:0] hdr2;
		logic [191:0] blk;
		logic [63:0] got;
		logic [31:0] flags;
		v = vectors[idx];
		// Header bytes are noise and must not reach any result
		hdr0 = 8'($urandom());
		hdr1 = 8'($urandom());
		hdr2 = 8'($urandom());
		blk = {v.pay2, hdr2, v.pay1, hdr1, v.pay0, hdr0, v.instr};
		for (int w = 0; w < 6; w++)
			write_reg(6'(w), blk[32*w +: 32], 4'hF);
		write_reg(qdc_pkg::REG_CTRL, 32'd1, 4'hF);
		read_imm64(qdc_pkg::REG_IMM0, got);
		check($sformatf("vector %0d imma", idx), v.imma, got);
		read_imm64(qdc_pkg::REG_IMM2, got);
		check($sformatf("vector %0d immb", idx), v.immb, got);
		read_imm64(qdc_pkg::REG_IMM4, got);
		check($sformatf("vector %0d immc", idx), v.immc, got);
		read_imm64(qdc_pkg::REG_IMM6, got);
		check($sformatf("vector %0d immd", idx), v.immd, got);
		read_reg(qdc_pkg::REG_FLAGS, flags);
		check($sformatf("vector %0d has_imm", idx), 64'(v.has_imm), 64'(flags[3:0]));
		check($sformatf("vector %0d isz", idx), 64'(v.isz), 64'(flags[9:4]));
		check($sformatf("vector %0d pos", idx), 64'(v.pos), 64'(flags[21:10]));
		check($sformatf("vector %0d flags top", idx), 64'd0, 64'(flags[31:22]));
	endtask

	// Hard stop if the bus stalls
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	initial
	begin
		void'($urandom(32'h2c654668));
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		sel = 4'h0;
		fill_vectors();
		@(posedge rst_n);
		@(posedge clk);
		#2;
		after_reset_zero();
		byte_lane_writes();
		for (int i = 0; i < NUM_VECTORS; i++)
			run_vector(i);
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/qdc_pkg.sv
hw/constant_decoder.sv
hw/fp_widen.sv
hw/decode_const.sv
hw/wb_decode_regs.sv
hw/decode_const_top.sv
verification/tb_clock_gen.sv
verification/tb_decode_const.sv

// ==== Makefile ====
# Verilator build and run for the constant-decode testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_decode_const
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= >>> PASS

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
